// File: list.f
+incdir+include
src/udp_echo_pkg.sv
src/udp_echo_dispatch.sv
src/udp_echo_out_ctrl.sv
src/udp_echo_lane.sv
src/udp_echo_merge.sv
src/udp_echo_top.sv
verif/udp_echo_tb.sv

// File: verif/udp_echo_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "udp_echo_defs.svh"

module udp_echo_tb;

    logic                   clk = 1'b0;
    logic                   reset_curr_flits_num;
    logic                   in_val;
    logic [`FLIT_WIDTH-1:0] in_flit;
    logic                   in_rdy;
    logic                   out_val;
    logic [`FLIT_WIDTH-1:0] out_flit;
    logic                   out_rdy;

    logic [`FLIT_WIDTH-1:0] exp_q[$];
    logic [31:0]            stim_rng;
    logic [31:0]            rdy_rng;
    logic                   bp_on;
    int                     errors;
    int                     flits_sent;
    int                     flits_rcvd;

    udp_echo_top u_udp_echo_top (
        .clk                  (clk),
        .reset_curr_flits_num (reset_curr_flits_num),
        .in_val               (in_val),
        .in_flit              (in_flit),
        .in_rdy               (in_rdy),
        .out_val              (out_val),
        .out_flit             (out_flit),
        .out_rdy              (out_rdy)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] lcg_step(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function logic [31:0] next_stim();
        stim_rng = lcg_step(stim_rng);
        return stim_rng;
    endfunction

    // Called at 1 ns after a rising edge, returns 1 ns after the transfer edge
    task automatic drive_flit(input logic [`FLIT_WIDTH-1:0] flit);
        in_val = 1'b1;
        in_flit = flit;
        @(negedge clk);
        while (!in_rdy) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        in_val = 1'b0;
        flits_sent++;
    endtask

    task automatic send_msg(input logic [7:0] total, input logic [23:0] tag,
                            input logic [15:0] sport, input logic [15:0] dport,
                            input logic [31:0] saddr, input logic [31:0] daddr,
                            input logic gaps);
        logic [`FLIT_WIDTH-1:0] data;
        logic [31:0]            r;
        exp_q.push_back({tag, sport, dport, total});
        exp_q.push_back({saddr, daddr});
        drive_flit({tag, dport, sport, total});
        drive_flit({daddr, saddr});
        for (int i = 1; i < total; i++) begin
            data = {next_stim(), next_stim()};
            exp_q.push_back(data);
            // Idle input between data flits lets a lane FIFO run dry
            r = next_stim();
            if (gaps && r[9:8] == 2'd0) begin
                repeat (int'(r[11:10]) + 1) @(posedge clk);
                #1;
            end
            drive_flit(data);
        end
    endtask

    task automatic random_msg(input logic gaps);
        logic [31:0] r;
        logic [7:0]  total;
        r = next_stim();
        total = 8'(r[19:16] % 12) + 8'd1;
        send_msg(total, next_stim() >> 8, next_stim() >> 16, next_stim() >> 16,
                 next_stim(), next_stim(), gaps);
        r = next_stim();
        if (gaps && r[20:18] < 3'd3) begin
            repeat (int'(r[23:22]) + 1) @(posedge clk);
            #1;
        end
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (10) @(posedge clk);
        #1;
    endtask

    always begin : out_rdy_drive
        @(posedge clk);
        #1;
        rdy_rng = lcg_step(rdy_rng);
        out_rdy = bp_on ? rdy_rng[16] : 1'b1;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    assert property (@(negedge clk) reset_curr_flits_num |-> !in_rdy)
        else begin
            errors++;
            $display("[FAIL] in_rdy expected 0 got %h", in_rdy);
        end

    assert property (@(posedge clk) $fell(reset_curr_flits_num) |-> !out_val)
        else begin
            errors++;
            $display("[FAIL] out_val expected 0 got %h", $sampled(out_val));
        end

    // Input still closed in the first cycle out of reset
    assert property (@(posedge clk) $fell(reset_curr_flits_num) |-> !in_rdy)
        else begin
            errors++;
            $display("[FAIL] in_rdy expected 0 got %h", $sampled(in_rdy));
        end

    // Stalled flit must hold
    assert property (@(posedge clk) disable iff (reset_curr_flits_num)
                     (out_val && !out_rdy) |=> (out_val && $stable(out_flit)))
        else begin
            errors++;
            $display("out_flit or out_val changed during a stall at %0t ns", $time);
        end

    always @(negedge clk) begin
        if (!reset_curr_flits_num && out_val && out_rdy) begin
            flits_rcvd++;
            assert (exp_q.size() > 0)
                else begin
                    errors++;
                    $display("Output flit %h appeared with nothing expected", out_flit);
                end
            if (exp_q.size() > 0) begin
                assert (out_flit === exp_q[0])
                    else begin
                        errors++;
                        $display("[FAIL] out_flit expected %h got %h", exp_q[0], out_flit);
                    end
                void'(exp_q.pop_front());
            end
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles <= flits_sent * 20 + 200) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles with %0d flits still expected",
                 cycles, exp_q.size());
        $display("Simulation FAILED");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    initial begin
        reset_curr_flits_num = 1'b1;
        in_val = 1'b0;
        in_flit = '0;
        out_rdy = 1'b0;
        bp_on = 1'b0;
        errors = 0;
        flits_sent = 0;
        flits_rcvd = 0;
        stim_rng = 32'ha907;
        rdy_rng = lcg_step(lcg_step(32'ha907));
        repeat (5) @(posedge clk);
        #1;
        reset_curr_flits_num = 1'b0;

        send_msg(8'd5, 24'h5a5a5a, 16'h1234, 16'hbeef, 32'h0a000001, 32'hc0a80001, 1'b0);
        wait_drain();

        // Header and metadata only, then a short follower
        send_msg(8'd1, 24'h00c3c3, 16'h0007, 16'h0900, 32'h11112222, 32'h33334444, 1'b0);
        send_msg(8'd3, 24'h123456, 16'h4321, 16'h8765, 32'hdeadbeef, 32'hcafef00d, 1'b0);
        wait_drain();

        repeat (30) random_msg(1'b0);
        wait_drain();

        bp_on = 1'b1;
        repeat (30) random_msg(1'b1);
        wait_drain();

        assert (flits_rcvd == flits_sent)
            else begin
                errors++;
                $display("[FAIL] flits_rcvd expected %h got %h", flits_sent, flits_rcvd);
            end
        $display("%0d flits sent, %0d flits received, %0d errors",
                 flits_sent, flits_rcvd, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src/udp_echo_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "udp_echo_defs.svh"

module udp_echo_top (
    input  wire                     clk,
    input  wire                     reset_curr_flits_num,
    input  wire                     in_val,
    input  wire  [`FLIT_WIDTH-1:0]  in_flit,
    output logic                    in_rdy,
    output logic                    out_val,
    output logic [`FLIT_WIDTH-1:0]  out_flit,
    input  wire                     out_rdy
);

    logic [`FLIT_WIDTH-1:0]                 lane_flit;
    logic [`NUM_LANES-1:0]                  lane_hdr_val;
    logic [`NUM_LANES-1:0]                  lane_meta_val;
    logic [`NUM_LANES-1:0]                  lane_data_val;
    logic [`NUM_LANES-1:0]                  lane_hdr_rdy;
    logic [`NUM_LANES-1:0]                  lane_data_rdy;
    logic [`NUM_LANES-1:0]                  lane_out_val;
    logic [`NUM_LANES-1:0][`FLIT_WIDTH-1:0] lane_out_flit;
    logic [`NUM_LANES-1:0]                  lane_out_last;
    logic [`NUM_LANES-1:0]                  lane_out_rdy;

    udp_echo_dispatch u_dispatch (
        .clk                  (clk),
        .reset_curr_flits_num (reset_curr_flits_num),
        .in_val               (in_val),
        .in_flit              (in_flit),
        .in_rdy               (in_rdy),
        .lane_hdr_rdy         (lane_hdr_rdy),
        .lane_data_rdy        (lane_data_rdy),
        .lane_flit            (lane_flit),
        .lane_hdr_val         (lane_hdr_val),
        .lane_meta_val        (lane_meta_val),
        .lane_data_val        (lane_data_val)
    );

    for (genvar i = 0; i < `NUM_LANES; i++) begin : g_lane
        udp_echo_lane u_lane (
            .clk                  (clk),
            .reset_curr_flits_num (reset_curr_flits_num),
            .lane_flit            (lane_flit),
            .hdr_val              (lane_hdr_val[i]),
            .meta_val             (lane_meta_val[i]),
            .data_val             (lane_data_val[i]),
            .hdr_rdy              (lane_hdr_rdy[i]),
            .data_rdy             (lane_data_rdy[i]),
            .out_val              (lane_out_val[i]),
            .out_flit             (lane_out_flit[i]),
            .out_last             (lane_out_last[i]),
            .out_rdy              (lane_out_rdy[i])
        );
    end

    udp_echo_merge u_merge (
        .clk                  (clk),
        .reset_curr_flits_num (reset_curr_flits_num),
        .lane_out_val         (lane_out_val),
        .lane_out_flit        (lane_out_flit),
        .lane_out_last        (lane_out_last),
        .lane_out_rdy         (lane_out_rdy),
        .out_val              (out_val),
        .out_flit             (out_flit),
        .out_rdy              (out_rdy)
    );

endmodule

`default_nettype wire

// File: src/udp_echo_merge.sv
`timescale 1ns/1ps
`default_nettype none
`include "udp_echo_defs.svh"

module udp_echo_merge (
    input  wire                                    clk,
    input  wire                                    reset_curr_flits_num,
    input  wire  [`NUM_LANES-1:0]                  lane_out_val,
    input  wire  [`NUM_LANES-1:0][`FLIT_WIDTH-1:0] lane_out_flit,
    input  wire  [`NUM_LANES-1:0]                  lane_out_last,
    output logic [`NUM_LANES-1:0]                  lane_out_rdy,
    output logic                                   out_val,
    output logic [`FLIT_WIDTH-1:0]                 out_flit,
    input  wire                                    out_rdy
);

    localparam int TURN_W = $clog2(`NUM_LANES);
    localparam logic [TURN_W-1:0] LAST_TURN = TURN_W'(`NUM_LANES - 1);
    localparam logic [`NUM_LANES-1:0] LANE0_ONEHOT = 1;

    logic [TURN_W-1:0]     turn_reg;
    logic [`NUM_LANES-1:0] turn_onehot;
    logic                  msg_end;

    // Same rotation as the dispatcher keeps output in input order
    always_ff @(posedge clk) begin
        if (reset_curr_flits_num) begin
            turn_reg <= '0;
        end else if (msg_end) begin
            turn_reg <= (turn_reg == LAST_TURN) ? '0 : turn_reg + 1'b1;
        end
    end

    assign turn_onehot = LANE0_ONEHOT << turn_reg;

    assign out_val = lane_out_val[turn_reg];
    assign out_flit = lane_out_flit[turn_reg];
    assign lane_out_rdy = turn_onehot & {`NUM_LANES{out_rdy}};

    assign msg_end = out_val & out_rdy & lane_out_last[turn_reg];

endmodule

`default_nettype wire

// File: src/udp_echo_lane.sv
`timescale 1ns/1ps
`default_nettype none
`include "udp_echo_defs.svh"

module udp_echo_lane (
    input  wire                     clk,
    input  wire                     reset_curr_flits_num,
    input  wire  [`FLIT_WIDTH-1:0]  lane_flit,
    input  wire                     hdr_val,
    input  wire                     meta_val,
    input  wire                     data_val,
    output logic                    hdr_rdy,
    output logic                    data_rdy,
    output logic                    out_val,
    output logic [`FLIT_WIDTH-1:0]  out_flit,
    output logic                    out_last,
    input  wire                     out_rdy
);
    import udp_echo_pkg::*;

    localparam int ADDR_W = $clog2(`LANE_FIFO_DEPTH);

    logic [`FLIT_WIDTH-1:0] hdr_reg;
    logic [`FLIT_WIDTH-1:0] meta_reg;
    logic                   hdr_full;
    logic                   meta_full;
    logic                   busy;
    logic                   hdr_done;
    logic                   meta_done;
    out_mux_sel_e           mux_sel;

    logic [`FLIT_WIDTH-1:0] fifo_mem [`LANE_FIFO_DEPTH];
    logic [ADDR_W:0]        wr_ptr;
    logic [ADDR_W:0]        rd_ptr;
    logic                   fifo_empty;
    logic                   fifo_full;
    logic                   fifo_rdy;
    logic                   fifo_pop;

    ////////////////////////////////////////////////////////////////////////////
    // Header and metadata capture, fields swapped on the way in
    always_ff @(posedge clk) begin
        if (hdr_val) begin
            hdr_reg <= {lane_flit[`FLIT_WIDTH-1:40], lane_flit[23:8],
                        lane_flit[39:24], lane_flit[7:0]};
        end
        if (meta_val) begin
            meta_reg <= {lane_flit[31:0], lane_flit[`FLIT_WIDTH-1:32]};
        end
    end

    always_ff @(posedge clk) begin
        if (reset_curr_flits_num) begin
            hdr_full <= 1'b0;
            meta_full <= 1'b0;
            busy <= 1'b0;
        end else begin
            if (hdr_val) begin
                hdr_full <= 1'b1;
            end else if (hdr_done) begin
                hdr_full <= 1'b0;
            end
            if (meta_val) begin
                meta_full <= 1'b1;
            end else if (meta_done) begin
                meta_full <= 1'b0;
            end
            // Held until the last flit leaves so total_flits stays put
            if (hdr_val) begin
                busy <= 1'b1;
            end else if (out_val & out_rdy & out_last) begin
                busy <= 1'b0;
            end
        end
    end

    assign hdr_rdy = ~busy & ~hdr_full & ~meta_full;

    ////////////////////////////////////////////////////////////////////////////
    // Data FIFO
    always_ff @(posedge clk) begin
        if (data_val) begin
            fifo_mem[wr_ptr[ADDR_W-1:0]] <= lane_flit;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_curr_flits_num) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (data_val) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (fifo_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    assign fifo_empty = (wr_ptr == rd_ptr);
    assign fifo_full = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
                       (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);
    assign data_rdy = ~fifo_full;
    // Controller ready alone does not mean a flit left
    assign fifo_pop = fifo_rdy & ~fifo_empty;

    udp_echo_out_ctrl u_out_ctrl (
        .clk                  (clk),
        .reset_curr_flits_num (reset_curr_flits_num),
        .noc_out_rdy          (out_rdy),
        .in_data_val          (~fifo_empty),
        // Header waits until the metadata is in as well
        .hdr_flit_val         (hdr_full & meta_full),
        .meta_flit_val        (meta_full),
        .total_flits          (hdr_reg[`MSG_LENGTH_WIDTH-1:0]),
        .noc_out_val          (out_val),
        .out_data_rdy         (fifo_rdy),
        .out_data_mux_sel     (mux_sel),
        .last_flit            (out_last),
        .hdr_done             (hdr_done),
        .meta_done            (meta_done)
    );

    always_comb begin
        case (mux_sel)
            HDR_FLIT:  out_flit = hdr_reg;
            META_FLIT: out_flit = meta_reg;
            default:   out_flit = fifo_mem[rd_ptr[ADDR_W-1:0]];
        endcase
    end

endmodule

`default_nettype wire

// File: src/udp_echo_out_ctrl.sv
`timescale 1ns/1ps
`default_nettype none
`include "udp_echo_defs.svh"

module udp_echo_out_ctrl (
    input  wire                           clk,
    input  wire                           reset_curr_flits_num,
    input  wire                           noc_out_rdy,
    output logic                          noc_out_val,
    input  wire                           in_data_val,
    output logic                          out_data_rdy,
    input  wire                           hdr_flit_val,
    input  wire                           meta_flit_val,
    input  wire [`MSG_LENGTH_WIDTH-1:0]   total_flits,
    output udp_echo_pkg::out_mux_sel_e    out_data_mux_sel,
    output logic                          last_flit,
    output logic                          hdr_done,
    output logic                          meta_done
);
    import udp_echo_pkg::*;

    out_state_e state_reg;
    out_state_e state_next;

    logic [`MSG_LENGTH_WIDTH-1:0] curr_flit_num_reg;
    logic [`MSG_LENGTH_WIDTH-1:0] curr_flit_num_next;
    logic                         clear_flit_count;
    logic                         incr_flit_count;
    logic                         at_last;

    always_ff @(posedge clk) begin
        if (reset_curr_flits_num) begin
            state_reg <= READY;
            curr_flit_num_reg <= '0;
        end else begin
            state_reg <= state_next;
            curr_flit_num_reg <= curr_flit_num_next;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Flit counter, header is flit 0
    always_comb begin
        if (clear_flit_count) begin
            curr_flit_num_next = incr_flit_count ? `MSG_LENGTH_WIDTH'(1) : '0;
        end else if (incr_flit_count) begin
            curr_flit_num_next = curr_flit_num_reg + 1'b1;
        end else begin
            curr_flit_num_next = curr_flit_num_reg;
        end
    end

    assign at_last = (curr_flit_num_reg == total_flits);
    assign last_flit = (state_reg != READY) & at_last;

    ////////////////////////////////////////////////////////////////////////////
    // Output sequencing
    always_comb begin
        noc_out_val = 1'b0;
        out_data_mux_sel = DATA_FLITS;
        out_data_rdy = 1'b0;
        clear_flit_count = 1'b0;
        incr_flit_count = 1'b0;
        hdr_done = 1'b0;
        meta_done = 1'b0;
        state_next = state_reg;
        case (state_reg)
            READY: begin
                noc_out_val = hdr_flit_val;
                out_data_mux_sel = HDR_FLIT;
                clear_flit_count = 1'b1;
                if (hdr_flit_val & noc_out_rdy) begin
                    incr_flit_count = 1'b1;
                    hdr_done = 1'b1;
                    state_next = META_FLIT_OUT;
                end
            end
            META_FLIT_OUT: begin
                noc_out_val = meta_flit_val;
                out_data_mux_sel = META_FLIT;
                if (meta_flit_val & noc_out_rdy) begin
                    incr_flit_count = 1'b1;
                    meta_done = 1'b1;
                    // total_flits of 1 means no data follows
                    state_next = at_last ? READY : DATA_PASSTHRU;
                end
            end
            DATA_PASSTHRU: begin
                noc_out_val = in_data_val;
                out_data_mux_sel = DATA_FLITS;
                out_data_rdy = noc_out_rdy;
                if (in_data_val & noc_out_rdy) begin
                    incr_flit_count = 1'b1;
                    if (at_last) begin
                        state_next = READY;
                    end
                end
            end
            default: begin
                state_next = READY;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: src/udp_echo_dispatch.sv
`timescale 1ns/1ps
`default_nettype none
`include "udp_echo_defs.svh"

module udp_echo_dispatch (
    input  wire                          clk,
    input  wire                          reset_curr_flits_num,
    input  wire                          in_val,
    input  wire  [`FLIT_WIDTH-1:0]       in_flit,
    output logic                         in_rdy,
    input  wire  [`NUM_LANES-1:0]        lane_hdr_rdy,
    input  wire  [`NUM_LANES-1:0]        lane_data_rdy,
    output logic [`FLIT_WIDTH-1:0]       lane_flit,
    output logic [`NUM_LANES-1:0]        lane_hdr_val,
    output logic [`NUM_LANES-1:0]        lane_meta_val,
    output logic [`NUM_LANES-1:0]        lane_data_val
);
    import udp_echo_pkg::*;

    localparam int TURN_W = $clog2(`NUM_LANES);
    localparam logic [TURN_W-1:0] LAST_TURN = TURN_W'(`NUM_LANES - 1);
    localparam logic [`NUM_LANES-1:0] LANE0_ONEHOT = 1;

    disp_state_e                  state_reg;
    disp_state_e                  state_next;
    logic [TURN_W-1:0]            turn_reg;
    logic [`MSG_LENGTH_WIDTH-1:0] data_cnt_reg;
    logic [`MSG_LENGTH_WIDTH-1:0] data_cnt_next;
    logic                         active_reg;
    logic [`NUM_LANES-1:0]        turn_onehot;
    logic                         xfer;
    logic                         advance;

    always_ff @(posedge clk) begin
        if (reset_curr_flits_num) begin
            state_reg <= WAIT_HDR;
            turn_reg <= '0;
            data_cnt_reg <= '0;
            active_reg <= 1'b0;
        end else begin
            state_reg <= state_next;
            data_cnt_reg <= data_cnt_next;
            // Input stays closed for the first cycle out of reset
            active_reg <= 1'b1;
            if (advance) begin
                turn_reg <= (turn_reg == LAST_TURN) ? '0 : turn_reg + 1'b1;
            end
        end
    end

    assign turn_onehot = LANE0_ONEHOT << turn_reg;
    assign lane_flit = in_flit;
    assign xfer = in_val & in_rdy;

    always_comb begin
        case (state_reg)
            WAIT_HDR:  in_rdy = active_reg & lane_hdr_rdy[turn_reg];
            // Lane always has room for the metadata
            SEND_META: in_rdy = active_reg;
            SEND_DATA: in_rdy = active_reg & lane_data_rdy[turn_reg];
            default:   in_rdy = 1'b0;
        endcase
    end

    always_comb begin
        lane_hdr_val = '0;
        lane_meta_val = '0;
        lane_data_val = '0;
        state_next = state_reg;
        data_cnt_next = data_cnt_reg;
        advance = 1'b0;
        case (state_reg)
            WAIT_HDR: begin
                if (xfer) begin
                    lane_hdr_val = turn_onehot;
                    data_cnt_next = in_flit[`MSG_LENGTH_WIDTH-1:0] - 1'b1;
                    state_next = SEND_META;
                end
            end
            SEND_META: begin
                if (xfer) begin
                    lane_meta_val = turn_onehot;
                    if (data_cnt_reg == '0) begin
                        advance = 1'b1;
                        state_next = WAIT_HDR;
                    end else begin
                        state_next = SEND_DATA;
                    end
                end
            end
            SEND_DATA: begin
                if (xfer) begin
                    lane_data_val = turn_onehot;
                    data_cnt_next = data_cnt_reg - 1'b1;
                    if (data_cnt_reg == 1) begin
                        advance = 1'b1;
                        state_next = WAIT_HDR;
                    end
                end
            end
            default: begin
                state_next = WAIT_HDR;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: src/udp_echo_pkg.sv
`default_nettype none

package udp_echo_pkg;

    // Which flit a lane presents at its output
    typedef enum logic [1:0] {
        HDR_FLIT   = 2'd0,
        META_FLIT  = 2'd1,
        DATA_FLITS = 2'd2
    } out_mux_sel_e;

    typedef enum logic [1:0] {
        READY         = 2'd0,
        META_FLIT_OUT = 2'd1,
        DATA_PASSTHRU = 2'd2
    } out_state_e;

    typedef enum logic [1:0] {
        WAIT_HDR  = 2'd0,
        SEND_META = 2'd1,
        SEND_DATA = 2'd2
    } disp_state_e;

endpackage

`default_nettype wire

// File: include/udp_echo_defs.svh
`ifndef UDP_ECHO_DEFS_SVH
`define UDP_ECHO_DEFS_SVH

// Header flit
//   [7:0]   total_flits, flits that follow the header, at least 1
//   [23:8]  source port
//   [39:24] destination port
//   Echo swaps the two port fields, other bits unchanged
// Metadata flit
//   [31:0]  source address
//   [63:32] destination address
//   Echo swaps the two address fields

`define FLIT_WIDTH       64
`define MSG_LENGTH_WIDTH 8
`define NUM_LANES        4
`define LANE_FIFO_DEPTH  4

`endif
